//--- list.f
+incdir+include
logic/fma_pkg.sv
logic/fma_round.sv
logic/fma_special.sv
logic/fma_core.sv
logic/fma_cfg_regs.sv
logic/fma_top.sv
verification/fma_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= fma_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= test passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- include/fma_tb_model.svh
`ifndef FMA_TB_MODEL_SVH
`define FMA_TB_MODEL_SVH

// exact integer to single precision under a rounding mode
function automatic logic [fp_width-1:0] round_int(input longint v, input logic [2:0] mode,
                                                  output logic inexact);
  logic        sgn;
  logic [63:0] mag;
  logic [63:0] man;
  int          msb;
  int          sh;
  int          e;
  logic        g, r, s, inc;
  sgn = (v < 0);
  mag = sgn ? -v : v;
  msb = 0;
  g = 1'b0;
  r = 1'b0;
  s = 1'b0;
  inexact = 1'b0;
  if (mag == 0) return '0;
  for (int i = 0; i < 64; i++) if (mag[i]) msb = i;
  if (msb <= man_width) begin
    man = mag << (man_width - msb);
  end else begin
    sh = msb - man_width;
    man = mag >> sh;
    g = mag[sh-1];
    r = (sh >= 2) ? mag[sh-2] : 1'b0;
    s = (sh >= 3) ? ((mag & ((64'd1 << (sh - 2)) - 1)) != 0) : 1'b0;
  end
  case (mode)
    rm_rtz:  inc = 1'b0;
    rm_rdn:  inc = sgn & (g | r | s);
    rm_rup:  inc = ~sgn & (g | r | s);
    rm_rmm:  inc = g;
    default: inc = g & (r | s | man[0]);
  endcase
  man = man + inc;
  e = msb;
  if (man[man_width+1]) begin
    man = man >> 1;
    e++;
  end
  inexact = g | r | s;
  if (e > exp_bias) return {sgn, exp_width'(inf_exp), {man_width{1'b0}}};
  return {sgn, exp_width'(e + exp_bias), man[man_width-1:0]};
endfunction

function automatic logic [fp_width-1:0] int_to_float(input longint v);
  logic unused_inexact;
  return round_int(v, rm_rne, unused_inexact);
endfunction

// expected result of the operation on integer operands
function automatic logic [fp_width-1:0] fma_expect(input longint a, input longint b,
                                                   input longint c, input logic [1:0] op,
                                                   input logic [2:0] mode,
                                                   output logic inexact);
  longint p;
  longint v;
  p = a * b;
  v = 0;
  inexact = 1'b0;
  case (op)
    op_madd:  v = p + c;
    op_msub:  v = p - c;
    op_nmsub: v = c - p;
    op_nmadd: v = -p - c;
  endcase
  // zero product plus zero keeps the sign only when both are negative
  if (p == 0 && c == 0) return {((a < 0) ^ (b < 0) ^ op[1]) & op[0], {(fp_width - 1){1'b0}}};
  if (v == 0) return {mode == rm_rdn, {(fp_width - 1){1'b0}}};
  return round_int(v, mode, inexact);
endfunction

`endif

//--- verification/fma_tb.sv
`timescale 1ns/1ns

module fma_tb import fma_pkg::*; ();

  `include "fma_tb_model.svh"

  logic                clk;
  logic                rst;
  logic [fp_width-1:0] a;
  logic [fp_width-1:0] b;
  logic [fp_width-1:0] c;
  logic                cfg_we;
  logic [2:0]          cfg_rm;
  logic [1:0]          cfg_op;
  logic [fp_width-1:0] result;
  logic                result_stb;
  logic [2:0]          sticky_flags;

  int         errors;
  // set once a strobe fails to arrive, later operations are skipped
  bit         timed_out;
  logic [2:0] cur_rm;
  logic [1:0] cur_op;
  // flags expected in the sticky register, {inexact, overflow, invalid}
  logic [2:0] exp_sticky;

  fma_top uut (
    .clk          (clk),
    .rst          (rst),
    .a            (a),
    .b            (b),
    .c            (c),
    .cfg_we       (cfg_we),
    .cfg_rm       (cfg_rm),
    .cfg_op       (cfg_op),
    .result       (result),
    .result_stb   (result_stb),
    .sticky_flags (sticky_flags)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic end_run();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  endtask

  // called on the falling edge of a strobe cycle, returns on the next one
  task automatic wait_result(input string name);
    int cycles;
    cycles = 0;
    if (timed_out) return;
    @(negedge clk);
    while (!result_stb && cycles < 200) begin
      @(negedge clk);
      cycles++;
    end
    if (!result_stb) begin
      $display("timeout: no result strobe within 200 cycles in %s", name);
      errors++;
      timed_out = 1'b1;
    end
  endtask

  task automatic check_op(input string name, input logic [fp_width-1:0] exp_z,
                          input logic [2:0] exp_flags);
    logic [2:0] got_flags;
    if (timed_out) return;
    got_flags = {uut.flag_inexact, uut.flag_overflow, uut.flag_invalid};
    assert (result === exp_z) else begin
      $display("mismatch %s result: expected %h, actual %h", name, exp_z, result);
      errors++;
    end
    assert (got_flags === exp_flags) else begin
      $display("mismatch %s flags: expected %b, actual %b", name, exp_flags, got_flags);
      errors++;
    end
    // the register only picks up this result's flags on the coming edge
    assert (sticky_flags === exp_sticky) else begin
      $display("mismatch %s sticky: expected %b, actual %b", name, exp_sticky, sticky_flags);
      errors++;
    end
    exp_sticky = exp_sticky | exp_flags;
  endtask

  task automatic run_op(input string name, input logic [fp_width-1:0] av,
                        input logic [fp_width-1:0] bv, input logic [fp_width-1:0] cv,
                        input logic [fp_width-1:0] exp_z, input logic [2:0] exp_flags);
    a = av;
    b = bv;
    c = cv;
    wait_result(name);
    check_op(name, exp_z, exp_flags);
  endtask

  task automatic run_int(input string name, input longint ai, input longint bi,
                         input longint ci);
    logic                inx;
    logic [fp_width-1:0] exp_z;
    exp_z = fma_expect(ai, bi, ci, cur_op, cur_rm, inx);
    run_op(name, int_to_float(ai), int_to_float(bi), int_to_float(ci), exp_z,
           {inx, 2'b00});
  endtask

  // the write lands on the edge where the core samples a flush operation,
  // so the new setting applies from the operation after it
  task automatic write_cfg(input logic [2:0] code, input logic [1:0] opv);
    cfg_we = 1'b1;
    cfg_rm = code;
    cfg_op = opv;
    a      = int_to_float(1);
    b      = int_to_float(1);
    c      = int_to_float(1);
    @(negedge clk);
    cfg_we     = 1'b0;
    cur_rm     = (code > rm_rmm) ? rm_rne : code;
    cur_op     = opv;
    exp_sticky = 3'b000;
    wait_result("cfg flush");
    if (!timed_out) begin
      assert (sticky_flags === 3'b000) else begin
        $display("sticky flags were not cleared by the configuration write (%b)",
                 sticky_flags);
        errors++;
      end
    end
  endtask

  initial begin
    logic                inx;
    logic [fp_width-1:0] exp_z;
    longint              ra, rb, rc;
    errors     = 0;
    timed_out  = 1'b0;
    exp_sticky = 3'b000;
    cur_rm     = rm_rne;
    cur_op     = op_madd;
    void'($urandom(32'hcb07_1ef0));
    rst    = 1'b1;
    cfg_we = 1'b0;
    cfg_rm = 3'd0;
    cfg_op = 2'd0;
    a      = int_to_float(3);
    b      = int_to_float(5);
    c      = int_to_float(7);

    repeat (8) begin
      @(negedge clk);
      assert (result_stb === 1'b0) else begin
        $display("result strobe is not low during reset");
        errors++;
      end
    end
    rst = 1'b0;

    // first result uses the reset configuration
    exp_z = fma_expect(3, 5, 7, op_madd, rm_rne, inx);
    wait_result("first after reset");
    check_op("first after reset", exp_z, {inx, 2'b00});

    // exact results for every operation code
    for (int k = 0; k < 4; k++) begin
      write_cfg(rm_rne, 2'(k));
      for (int n = 0; n < 4; n++) begin
        ra = longint'($urandom % 2001) - 1000;
        rb = longint'($urandom % 2001) - 1000;
        rc = longint'($urandom % 200001) - 100000;
        run_int($sformatf("exact op %0d", k), ra, rb, rc);
      end
    end

    // results wider than the mantissa under each rounding mode
    for (int m = 0; m <= 4; m++) begin
      write_cfg(3'(m), op_madd);
      run_int($sformatf("tie even rm %0d", m), 4096, 4096, 1);
      run_int($sformatf("tie odd rm %0d", m), 4096, 4096, 3);
      run_int($sformatf("tie negative rm %0d", m), -4096, 4096, -1);
      run_int($sformatf("inexact rm %0d", m), 4097, 4099, 1);
      for (int n = 0; n < 3; n++) begin
        ra = longint'($urandom % 61440) + 4096;
        rb = longint'($urandom % 61440) + 4096;
        rc = longint'($urandom % 2097153) - 1048576;
        if ($urandom % 2) ra = -ra;
        run_int($sformatf("random rm %0d", m), ra, rb, rc);
      end
    end

    // special cases in priority order, then overflow
    write_cfg(rm_rne, op_madd);
    run_op("nan a", 32'h7fc00000, 32'h3f800000, 32'h3f800000, qnan_value, 3'b000);
    run_op("nan c", 32'h3f800000, 32'h3f800000, 32'h7fc00001, qnan_value, 3'b000);
    run_op("inf times zero", 32'h7f800000, 32'h00000000, 32'h3f800000, qnan_value, 3'b001);
    run_op("opposite inf", 32'h7f800000, 32'h3f800000, 32'hff800000, qnan_value, 3'b001);
    run_op("inf product", 32'hff800000, 32'h40000000, 32'h3f800000, 32'hff800000, 3'b000);
    run_op("inf addend", 32'h3f800000, 32'h3f800000, 32'h7f800000, 32'h7f800000, 3'b000);
    run_op("zero product", 32'h00000000, 32'h40400000, 32'h40a00000, 32'h40a00000, 3'b000);
    run_op("signed zeros", 32'h80000000, 32'h3f800000, 32'h80000000, 32'h80000000, 3'b000);
    run_op("overflow pos", 32'h7f000000, 32'h40000000, 32'h00000000, 32'h7f800000, 3'b110);
    run_op("overflow neg", 32'hff000000, 32'h40000000, 32'h00000000, 32'hff800000, 3'b110);
    // all three flags are held by now
    run_int("after flags", 4097, 4099, 1);

    // code 6 is out of range and rounds like rne
    write_cfg(3'd6, op_madd);
    run_int("illegal mode tie even", 4096, 4096, 1);
    run_int("illegal mode tie odd", 4096, 4096, 3);

    end_run();
  end

endmodule

//--- logic/fma_top.sv
`timescale 1ns/1ns

module fma_top import fma_pkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  logic [fp_width-1:0] a,
  input  logic [fp_width-1:0] b,
  input  logic [fp_width-1:0] c,
  input  logic                cfg_we,
  input  logic [2:0]          cfg_rm,
  input  logic [1:0]          cfg_op,
  output logic [fp_width-1:0] result,
  output logic                result_stb,
  output logic [2:0]          sticky_flags
);

  logic [2:0] rm;
  logic [1:0] op;
  logic       flag_invalid;
  logic       flag_overflow;
  logic       flag_inexact;

  fma_cfg_regs u_cfg_regs (
    .clk           (clk),
    .rst           (rst),
    .cfg_we        (cfg_we),
    .cfg_rm        (cfg_rm),
    .cfg_op        (cfg_op),
    .result_stb    (result_stb),
    .flag_invalid  (flag_invalid),
    .flag_overflow (flag_overflow),
    .flag_inexact  (flag_inexact),
    .rm            (rm),
    .op            (op),
    .sticky_flags  (sticky_flags)
  );

  fma_core u_core (
    .clk           (clk),
    .rst           (rst),
    .a             (a),
    .b             (b),
    .c             (c),
    .rm            (rm),
    .op            (op),
    .result        (result),
    .result_stb    (result_stb),
    .flag_invalid  (flag_invalid),
    .flag_overflow (flag_overflow),
    .flag_inexact  (flag_inexact)
  );

endmodule

//--- logic/fma_cfg_regs.sv
`timescale 1ns/1ns

module fma_cfg_regs import fma_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       cfg_we,
  input  logic [2:0] cfg_rm,
  input  logic [1:0] cfg_op,
  input  logic       result_stb,
  input  logic       flag_invalid,
  input  logic       flag_overflow,
  input  logic       flag_inexact,
  output logic [2:0] rm,
  output logic [1:0] op,
  // bit 0 invalid, bit 1 overflow, bit 2 inexact
  output logic [2:0] sticky_flags
);

  always_ff @(posedge clk) begin
    if (rst) begin
      rm           <= rm_rne;
      op           <= op_madd;
      sticky_flags <= '0;
    end else if (cfg_we) begin
      // unknown rounding codes fall back to round-to-nearest-even
      rm           <= (cfg_rm > rm_rmm) ? rm_rne : cfg_rm;
      op           <= cfg_op;
      // a write clears the flags, even against a result in the same cycle
      sticky_flags <= '0;
    end else if (result_stb) begin
      sticky_flags <= sticky_flags | {flag_inexact, flag_overflow, flag_invalid};
    end
  end

endmodule

//--- logic/fma_core.sv
`timescale 1ns/1ns

module fma_core import fma_pkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  logic [fp_width-1:0] a,
  input  logic [fp_width-1:0] b,
  input  logic [fp_width-1:0] c,
  input  logic [2:0]          rm,
  input  logic [1:0]          op,
  output logic [fp_width-1:0] result,
  output logic                result_stb,
  output logic                flag_invalid,
  output logic                flag_overflow,
  output logic                flag_inexact
);

  typedef enum logic [3:0] {
    st_unpack,
    st_special,
    st_normalise,
    st_multiply,
    st_align,
    st_add,
    st_normalise_1,
    st_normalise_2,
    st_pack,
    st_put
  } state_t;

  state_t state;

  logic [2:0]                      rm_q;
  logic [1:0]                      op_q;
  logic                            a_s, b_s, c_s, t_s, z_s;
  logic signed [ext_exp_width-1:0] a_e, b_e, c_e, t_e, z_e;
  logic [man_width:0]              a_m, b_m, c_m, z_m;
  // product and addend share one 48-bit frame, msb weight 2^exponent
  logic [2*man_width+1:0]          t_m, c_w;
  logic [2*man_width+2:0]          sum;
  logic                            guard, round_bit, sticky;
  logic [fp_width-1:0]             z;
  logic                            z_inv, z_ovf, z_inx;

  logic                            prod_sign;
  logic                            is_special;
  logic                            sp_invalid;
  logic [fp_width-1:0]             special_z;

  logic signed [ext_exp_width-1:0] e_diff;
  logic [ext_exp_width-1:0]        e_dist;
  logic [5:0]                      sh_amt;
  logic [2*man_width+1:0]          small_m, small_sh, aligned;
  logic                            small_st;

  logic [man_width:0]              round_zm;
  logic signed [ext_exp_width-1:0] round_ze;
  logic                            round_inx;

  assign prod_sign = a_s ^ b_s ^ op_q[1];

  fma_special u_special (
    .a_s        (a_s),
    .a_e        (a_e),
    .a_m        (a_m[man_width-1:0]),
    .b_s        (b_s),
    .b_e        (b_e),
    .b_m        (b_m[man_width-1:0]),
    .c_s        (c_s),
    .c_e        (c_e),
    .c_m        (c_m[man_width-1:0]),
    .prod_sign  (prod_sign),
    .is_special (is_special),
    .special_z  (special_z),
    .invalid    (sp_invalid)
  );

  fma_round u_round (
    .man_in    (z_m),
    .exp_in    (z_e),
    .sign      (z_s),
    .guard     (guard),
    .round_bit (round_bit),
    .sticky    (sticky),
    .rm        (rm_q),
    .man_out   (round_zm),
    .exp_out   (round_ze),
    .inexact   (round_inx)
  );

  // the operand with the smaller exponent is shifted right in one step,
  // bits that fall off are folded into the lsb
  always_comb begin
    e_diff   = t_e - c_e;
    e_dist   = (e_diff < 0) ? -e_diff : e_diff;
    sh_amt   = (e_dist > 2*man_width+2) ? 6'(2*man_width+2) : e_dist[5:0];
    small_m  = (e_diff < 0) ? t_m : c_w;
    small_sh = small_m >> sh_amt;
    small_st = |(small_m & ~({(2*man_width+2){1'b1}} << sh_amt));
    aligned  = {small_sh[2*man_width+1:1], small_sh[0] | small_st};
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= st_unpack;
      result_stb    <= 1'b0;
      flag_invalid  <= 1'b0;
      flag_overflow <= 1'b0;
      flag_inexact  <= 1'b0;
    end else begin
      case (state)
        st_unpack: begin
          result_stb <= 1'b0;
          rm_q       <= rm;
          op_q       <= op;
          a_s        <= a[fp_width-1];
          b_s        <= b[fp_width-1];
          c_s        <= c[fp_width-1] ^ op[0];
          a_e <= ext_exp_width'(a[fp_width-2:man_width]) - ext_exp_width'(exp_bias);
          b_e <= ext_exp_width'(b[fp_width-2:man_width]) - ext_exp_width'(exp_bias);
          c_e <= ext_exp_width'(c[fp_width-2:man_width]) - ext_exp_width'(exp_bias);
          a_m        <= {1'b0, a[man_width-1:0]};
          b_m        <= {1'b0, b[man_width-1:0]};
          c_m        <= {1'b0, c[man_width-1:0]};
          z_inv      <= 1'b0;
          z_ovf      <= 1'b0;
          z_inx      <= 1'b0;
          state      <= st_special;
        end

        st_special: begin
          if (is_special) begin
            z     <= special_z;
            z_inv <= sp_invalid;
            state <= st_put;
          end else begin
            // denormals take the minimum exponent, normals get the hidden bit
            if (a_e == -exp_bias) a_e <= ext_exp_width'(1 - exp_bias);
            else a_m[man_width] <= 1'b1;
            if (b_e == -exp_bias) b_e <= ext_exp_width'(1 - exp_bias);
            else b_m[man_width] <= 1'b1;
            if (c_e == -exp_bias) c_e <= ext_exp_width'(1 - exp_bias);
            else c_m[man_width] <= 1'b1;
            state <= st_normalise;
          end
        end

        st_normalise: begin
          if (!a_m[man_width]) begin
            a_m <= a_m << 1;
            a_e <= a_e - ext_exp_width'(1);
          end
          if (!b_m[man_width]) begin
            b_m <= b_m << 1;
            b_e <= b_e - ext_exp_width'(1);
          end else if (a_m[man_width]) begin
            state <= st_multiply;
          end
        end

        st_multiply: begin
          t_s   <= prod_sign;
          t_e   <= a_e + b_e + ext_exp_width'(1);
          t_m   <= a_m * b_m;
          c_w   <= {c_m, {(man_width + 1){1'b0}}};
          state <= st_align;
        end

        st_align: begin
          // z_e names the weight of the sum's carry bit
          if (e_diff < 0) begin
            t_m <= aligned;
            z_e <= c_e + ext_exp_width'(1);
          end else begin
            c_w <= aligned;
            z_e <= t_e + ext_exp_width'(1);
          end
          state <= st_add;
        end

        st_add: begin
          if (t_s == c_s) begin
            sum <= {1'b0, t_m} + {1'b0, c_w};
            z_s <= t_s;
          end else if (t_m >= c_w) begin
            sum <= {1'b0, t_m} - {1'b0, c_w};
            z_s <= t_s;
          end else begin
            sum <= {1'b0, c_w} - {1'b0, t_m};
            z_s <= c_s;
          end
          state <= st_normalise_1;
        end

        st_normalise_1: begin
          if (sum == '0) begin
            // exact cancellation gives +0, or -0 when rounding down
            z     <= {rm_q == rm_rdn, {(fp_width - 1){1'b0}}};
            state <= st_put;
          end else if (!sum[2*man_width+2]) begin
            sum <= sum << 1;
            z_e <= z_e - ext_exp_width'(1);
          end else begin
            z_m       <= sum[2*man_width+2:man_width+2];
            guard     <= sum[man_width+1];
            round_bit <= sum[man_width];
            sticky    <= |sum[man_width-1:0];
            state     <= st_normalise_2;
          end
        end

        st_normalise_2: begin
          // below the normal range, shift right into a denormal
          if (z_e < 1 - exp_bias) begin
            z_e       <= z_e + ext_exp_width'(1);
            z_m       <= z_m >> 1;
            guard     <= z_m[0];
            round_bit <= guard;
            sticky    <= sticky | round_bit;
          end else begin
            state <= st_pack;
          end
        end

        st_pack: begin
          if (round_ze > exp_bias) begin
            z     <= {z_s, exp_width'(inf_exp), {man_width{1'b0}}};
            z_ovf <= 1'b1;
            z_inx <= 1'b1;
          end else begin
            z[fp_width-1]    <= z_s;
            z[man_width-1:0] <= round_zm[man_width-1:0];
            if (!round_zm[man_width])
              z[fp_width-2:man_width] <= '0;
            else
              z[fp_width-2:man_width] <= round_ze[exp_width-1:0] + exp_width'(exp_bias);
            z_inx <= round_inx;
          end
          state <= st_put;
        end

        st_put: begin
          result        <= z;
          result_stb    <= 1'b1;
          flag_invalid  <= z_inv;
          flag_overflow <= z_ovf;
          flag_inexact  <= z_inx;
          state         <= st_unpack;
        end

        default: state <= st_unpack;
      endcase
    end
  end

endmodule

//--- logic/fma_special.sv
`timescale 1ns/1ns

module fma_special import fma_pkg::*; (
  input  logic                             a_s,
  input  logic signed [ext_exp_width-1:0]  a_e,
  input  logic [man_width-1:0]             a_m,
  input  logic                             b_s,
  input  logic signed [ext_exp_width-1:0]  b_e,
  input  logic [man_width-1:0]             b_m,
  input  logic                             c_s,
  input  logic signed [ext_exp_width-1:0]  c_e,
  input  logic [man_width-1:0]             c_m,
  input  logic                             prod_sign,
  output logic                             is_special,
  output logic [fp_width-1:0]              special_z,
  output logic                             invalid
);

  logic a_nan, b_nan, c_nan;
  logic a_inf, b_inf, c_inf;
  logic a_zero, b_zero, c_zero;
  logic prod_inf, prod_zero;

  // unbiased exponents, so inf/nan sit at +128 and zero/denormal at -127
  assign a_nan  = (a_e == inf_exp - exp_bias) && (a_m != '0);
  assign b_nan  = (b_e == inf_exp - exp_bias) && (b_m != '0);
  assign c_nan  = (c_e == inf_exp - exp_bias) && (c_m != '0);
  assign a_inf  = (a_e == inf_exp - exp_bias) && (a_m == '0);
  assign b_inf  = (b_e == inf_exp - exp_bias) && (b_m == '0);
  assign c_inf  = (c_e == inf_exp - exp_bias) && (c_m == '0);
  assign a_zero = (a_e == -exp_bias) && (a_m == '0);
  assign b_zero = (b_e == -exp_bias) && (b_m == '0);
  assign c_zero = (c_e == -exp_bias) && (c_m == '0);

  assign prod_inf  = a_inf | b_inf;
  assign prod_zero = a_zero | b_zero;

  always_comb begin
    is_special = 1'b1;
    invalid    = 1'b0;
    special_z  = qnan_value;
    if (a_nan || b_nan || c_nan) begin
      special_z = qnan_value;
    end else if ((a_inf && b_zero) || (b_inf && a_zero)) begin
      invalid = 1'b1;
    end else if (prod_inf && c_inf && (prod_sign != c_s)) begin
      invalid = 1'b1;
    end else if (prod_inf) begin
      special_z = {prod_sign, exp_width'(inf_exp), {man_width{1'b0}}};
    end else if (c_inf) begin
      special_z = {c_s, exp_width'(inf_exp), {man_width{1'b0}}};
    end else if (prod_zero && c_zero) begin
      // 0 + 0 is negative only when both terms are
      special_z = {prod_sign & c_s, {(fp_width - 1){1'b0}}};
    end else if (prod_zero) begin
      special_z = {c_s, c_e[exp_width-1:0] + exp_width'(exp_bias), c_m};
    end else begin
      is_special = 1'b0;
    end
  end

endmodule

//--- logic/fma_round.sv
`timescale 1ns/1ns

module fma_round import fma_pkg::*; (
  input  logic [man_width:0]               man_in,
  input  logic signed [ext_exp_width-1:0]  exp_in,
  input  logic                             sign,
  input  logic                             guard,
  input  logic                             round_bit,
  input  logic                             sticky,
  input  logic [2:0]                       rm,
  output logic [man_width:0]               man_out,
  output logic signed [ext_exp_width-1:0]  exp_out,
  output logic                             inexact
);

  logic                 any_bit;
  logic                 inc;
  logic [man_width+1:0] man_inc;

  // anything below the lsb makes the result inexact
  assign any_bit = guard | round_bit | sticky;
  assign inexact = any_bit;

  always_comb begin
    case (rm)
      // ties go to the even mantissa
      rm_rne: inc = guard & (round_bit | sticky | man_in[0]);
      rm_rtz: inc = 1'b0;
      // toward -inf only moves negative magnitudes up
      rm_rdn: inc = sign & any_bit;
      rm_rup: inc = ~sign & any_bit;
      // ties away from zero
      rm_rmm: inc = guard;
      default: inc = 1'b0;
    endcase
  end

  assign man_inc = {1'b0, man_in} + {{(man_width + 1){1'b0}}, inc};

  // a carry out of the mantissa only happens from all ones, so the
  // shifted value is exactly the hidden bit
  always_comb begin
    if (man_inc[man_width+1]) begin
      man_out = man_inc[man_width+1:1];
      exp_out = exp_in + ext_exp_width'(1);
    end else begin
      man_out = man_inc[man_width:0];
      exp_out = exp_in;
    end
  end

endmodule

//--- logic/fma_pkg.sv
package fma_pkg;

  // single-precision layout
  localparam int fp_width  = 32;
  localparam int exp_width = 8;
  localparam int man_width = 23;
  localparam int exp_bias  = 127;

  // signed working exponent, wide enough for the product of two denormals
  localparam int ext_exp_width = 10;

  // biased exponent field of infinity and NaN
  localparam int inf_exp = 255;

  // rounding modes
  localparam logic [2:0] rm_rne = 3'd0;
  localparam logic [2:0] rm_rtz = 3'd1;
  localparam logic [2:0] rm_rdn = 3'd2;
  localparam logic [2:0] rm_rup = 3'd3;
  localparam logic [2:0] rm_rmm = 3'd4;

  // operation select, bit 0 negates c and bit 1 negates the product
  localparam logic [1:0] op_madd  = 2'b00;
  localparam logic [1:0] op_msub  = 2'b01;
  localparam logic [1:0] op_nmsub = 2'b10;
  localparam logic [1:0] op_nmadd = 2'b11;

  // every NaN result leaves as this one
  localparam logic [fp_width-1:0] qnan_value = 32'hffc00000;

endpackage
